// ==== core_ctrl.f ====
hw/ctrl_pkg.sv
hw/ctrl_fsm.sv
hw/trap_unit.sv
hw/core_ctrl.sv
test/core_ctrl_sva.sv
test/core_ctrl_tb.sv

// ==== hw/core_ctrl.sv ====
`default_nettype none

module core_ctrl #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         fetch_enable_i,
  input  wire logic                         instr_valid_i,
  input  wire logic                         id_ready_i,
  input  wire logic                         branch_set_i,
  input  wire logic                         jump_set_i,
  input  wire logic                         branch_in_id_i,
  input  wire logic                         multicycle_i,
  input  wire logic                         irq_req_i,
  input  wire logic [IRQ_ID_W-1:0]          irq_id_i,
  input  wire logic                         m_ie_i,
  input  wire ctrl_pkg::priv_lvl_e          priv_i,
  input  wire ctrl_pkg::dec_evt_t           dec_evt_i,
  output      logic                         busy_o,
  output      logic                         instr_req_o,
  output      logic                         halt_if_o,
  output      logic                         halt_id_o,
  output      logic                         first_fetch_o,
  output      logic                         is_decoding_o,
  output      logic                         deassert_we_o,
  output      ctrl_pkg::pc_ctrl_t           pc_ctrl_o,
  output      ctrl_pkg::csr_ctrl_t          csr_ctrl_o,
  output      logic [ctrl_pkg::CAUSE_W-1:0] exc_cause_o,
  output      logic [ctrl_pkg::CAUSE_W-1:0] csr_cause_o,
  output      logic                         irq_ack_o,
  output      logic                         exc_ack_o,
  output      logic [IRQ_ID_W-1:0]          irq_id_o
);

  import ctrl_pkg::*;

  // sequencer to trap encoder
  ctrl_act_e act;

  ////////////////////////////////////////
  // state sequencer
  ////////////////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .instr_valid_i  (instr_valid_i),
    .id_ready_i     (id_ready_i),
    .branch_set_i   (branch_set_i),
    .jump_set_i     (jump_set_i),
    .branch_in_id_i (branch_in_id_i),
    .multicycle_i   (multicycle_i),
    .irq_req_i      (irq_req_i),
    .m_ie_i         (m_ie_i),
    .dec_evt_i      (dec_evt_i),
    .act_o          (act),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .deassert_we_o  (deassert_we_o)
  );

  ////////////////////////////////////////
  // trap encoder
  ////////////////////////////////////////

  trap_unit #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_trap_unit (
    .act_i       (act),
    .dec_evt_i   (dec_evt_i),
    .irq_id_i    (irq_id_i),
    .priv_i      (priv_i),
    .pc_ctrl_o   (pc_ctrl_o),
    .csr_ctrl_o  (csr_ctrl_o),
    .exc_cause_o (exc_cause_o),
    .csr_cause_o (csr_cause_o),
    .irq_ack_o   (irq_ack_o),
    .exc_ack_o   (exc_ack_o),
    .irq_id_o    (irq_id_o)
  );

endmodule

`default_nettype wire

// ==== hw/ctrl_fsm.sv ====
`default_nettype none

module ctrl_fsm (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // core enable, also wakes from sleep
  input  wire logic                fetch_enable_i,
  // IF/ID pipeline status
  input  wire logic                instr_valid_i,
  input  wire logic                id_ready_i,
  // redirect requests from ID
  input  wire logic                branch_set_i,
  input  wire logic                jump_set_i,
  input  wire logic                branch_in_id_i,
  input  wire logic                multicycle_i,
  // interrupt request and global enable
  input  wire logic                irq_req_i,
  input  wire logic                m_ie_i,
  input  wire ctrl_pkg::dec_evt_t  dec_evt_i,
  output      ctrl_pkg::ctrl_act_e act_o,
  output      logic                busy_o,
  output      logic                instr_req_o,
  output      logic                halt_if_o,
  output      logic                halt_id_o,
  output      logic                first_fetch_o,
  output      logic                is_decoding_o,
  output      logic                deassert_we_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // any decoder flag that needs a flush cycle
  logic flush_evt;
  // interrupt may be taken from an idle or harmless decode slot
  logic irq_ok;
  // flush ends in sleep instead of going back to decode
  logic sleep_req;

  assign flush_evt = dec_evt_i.illegal | dec_evt_i.ecall |
                     dec_evt_i.mret | dec_evt_i.pipe_flush;
  assign irq_ok    = irq_req_i & m_ie_i & ~multicycle_i & ~branch_in_id_i;
  assign sleep_req = ~fetch_enable_i & (dec_evt_i.mret | dec_evt_i.pipe_flush);

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb begin
    // defaults: running, fetching, no action
    state_d       = state_q;
    act_o         = ACT_NONE;
    busy_o        = 1'b1;
    instr_req_o   = 1'b1;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;

    case (state_q)
      // idle until the core gets enabled
      RESET: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch pc
      BOOT_SET: begin
        act_o   = ACT_BOOT;
        state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pipeline is empty here, so an enabled irq goes straight in
        if (irq_req_i && m_ie_i) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          // branch and jump redirect in the same cycle
          if (branch_set_i || jump_set_i) begin
            act_o = ACT_JUMP;
          end else if (flush_evt) begin
            // hold ID so the flags are still there in FLUSH
            state_d   = FLUSH;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else if (irq_ok) begin
            state_d   = IRQ_TAKEN;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end
        end else if (irq_req_i && m_ie_i) begin
          // bubble in ID, nothing to protect
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // vector to the handler, one cycle
      IRQ_TAKEN: begin
        act_o   = ACT_IRQ;
        state_d = DECODE;
      end

      // exception, eret or plain flush
      FLUSH: begin
        act_o     = ACT_FLUSH;
        halt_if_o = ~fetch_enable_i;
        halt_id_o = 1'b1;
        state_d   = sleep_req ? WAIT_SLEEP : DECODE;
      end

      // one cycle to let the pipe drain before sleeping
      WAIT_SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // wake on enable or on any irq request
      SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // write enable suppression
  ////////////////////////////////////////

  // no register write unless a legal instruction is decoded
  assign deassert_we_o = ~is_decoding_o | dec_evt_i.illegal;

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  ////////////////////////////////////////
  // widths and cause codes
  ////////////////////////////////////////

  // mcause field width
  localparam int unsigned CAUSE_W = 6;

  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL = 6'h02;
  // base for ecall, privilege level goes in the low bits
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL   = 6'h08;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // sequencer states
  typedef enum logic [2:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN, WAIT_SLEEP, SLEEP
  } ctrl_state_e;

  // what the sequencer asks the trap encoder for in this cycle
  typedef enum logic [2:0] {
    ACT_NONE, ACT_BOOT, ACT_JUMP, ACT_IRQ, ACT_FLUSH
  } ctrl_act_e;

  // fetch stage pc mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_sel_e;

  // exception vector select
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // decoder flags that force a pipe flush
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic pipe_flush;
  } dec_evt_t;

  // redirect towards the prefetcher
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_pc_sel;
  } pc_ctrl_t;

  // csr save and restore strobes
  typedef struct packed {
    logic save_if;
    logic save_id;
    logic save_cause;
    logic restore_mret;
  } csr_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/trap_unit.sv ====
`default_nettype none

module trap_unit #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire ctrl_pkg::ctrl_act_e          act_i,
  input  wire ctrl_pkg::dec_evt_t           dec_evt_i,
  input  wire logic [IRQ_ID_W-1:0]          irq_id_i,
  input  wire ctrl_pkg::priv_lvl_e          priv_i,
  output      ctrl_pkg::pc_ctrl_t           pc_ctrl_o,
  output      ctrl_pkg::csr_ctrl_t          csr_ctrl_o,
  output      logic [ctrl_pkg::CAUSE_W-1:0] exc_cause_o,
  output      logic [ctrl_pkg::CAUSE_W-1:0] csr_cause_o,
  output      logic                         irq_ack_o,
  output      logic                         exc_ack_o,
  output      logic [IRQ_ID_W-1:0]          irq_id_o
);

  import ctrl_pkg::*;

  // irq cause for the vector offset, msb clear
  logic [CAUSE_W-1:0] irq_exc_cause;
  // irq cause for mcause, interrupt bit set above the id
  logic [CAUSE_W-1:0] irq_csr_cause;
  // ecall cause depends on the current privilege level
  logic [CAUSE_W-1:0] ecall_cause;

  always_comb begin
    irq_exc_cause                 = '0;
    irq_exc_cause[IRQ_ID_W-1:0]   = irq_id_i;
    irq_csr_cause                 = irq_exc_cause;
    irq_csr_cause[IRQ_ID_W]       = 1'b1;
  end

  assign ecall_cause = EXC_CAUSE_ECALL | {{(CAUSE_W-2){1'b0}}, priv_i};

  // id goes back to the interrupt controller unchanged
  assign irq_id_o = irq_id_i;

  ////////////////////////////////////////
  // action decode
  ////////////////////////////////////////

  always_comb begin
    pc_ctrl_o   = '{pc_set: 1'b0, pc_sel: PC_BOOT, exc_pc_sel: EXC_PC_IRQ};
    csr_ctrl_o  = '0;
    exc_cause_o = '0;
    csr_cause_o = '0;
    irq_ack_o   = 1'b0;
    exc_ack_o   = 1'b0;

    case (act_i)
      ACT_BOOT: begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_sel = PC_BOOT;
      end

      ACT_JUMP: begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_sel = PC_JUMP;
      end

      // save the pc of the instruction in IF, it was not executed
      ACT_IRQ: begin
        pc_ctrl_o             = '{pc_set: 1'b1, pc_sel: PC_EXCEPTION, exc_pc_sel: EXC_PC_IRQ};
        exc_cause_o           = irq_exc_cause;
        csr_cause_o           = irq_csr_cause;
        csr_ctrl_o.save_if    = 1'b1;
        csr_ctrl_o.save_cause = 1'b1;
        irq_ack_o             = 1'b1;
        exc_ack_o             = 1'b1;
      end

      // ecall wins over illegal, illegal over mret
      ACT_FLUSH: begin
        if (dec_evt_i.ecall) begin
          pc_ctrl_o = '{pc_set: 1'b1, pc_sel: PC_EXCEPTION, exc_pc_sel: EXC_PC_ECALL};
          exc_cause_o           = ecall_cause;
          csr_cause_o           = ecall_cause;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
        end else if (dec_evt_i.illegal) begin
          pc_ctrl_o = '{pc_set: 1'b1, pc_sel: PC_EXCEPTION, exc_pc_sel: EXC_PC_ILLINSN};
          exc_cause_o           = EXC_CAUSE_ILLEGAL;
          csr_cause_o           = EXC_CAUSE_ILLEGAL;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
        end else if (dec_evt_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_sel        = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
        end
        // plain pipe flush has no redirect
      end

      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the core_ctrl testbench with Verilator and run it
# the run passes only if the pass line shows up in the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module core_ctrl_tb -f core_ctrl.f &&
./obj_dir/Vcore_ctrl_tb | tee /dev/stderr | grep "TEST PASS" > /dev/null ||
{ echo "core_ctrl simulation did not pass"; exit 1; }

// ==== test/core_ctrl_sva.sv ====
`default_nettype none

module core_ctrl_sva (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               m_ie_i,
  input wire logic               is_decoding_i,
  input wire logic               irq_ack_i,
  input wire ctrl_pkg::pc_ctrl_t pc_ctrl_i
);

  ////////////////////////////////////////
  // redirect and interrupt protocol
  ////////////////////////////////////////

  // boot, irq and flush redirects are single-cycle pulses
  // back-to-back pc_set only comes from jumps in decode
  property p_pc_set_pulse;
    @(posedge clk) disable iff (!rst_n)
      (pc_ctrl_i.pc_set && !is_decoding_i) |=> (!pc_ctrl_i.pc_set || is_decoding_i);
  endproperty

  // no irq ack without the global enable one cycle earlier
  property p_irq_needs_mie;
    @(posedge clk) disable iff (!rst_n)
      !m_ie_i |=> !irq_ack_i;
  endproperty

  a_pc_set_pulse: assert property (p_pc_set_pulse)
    else $error("pc_set held for two cycles outside decode");
  a_irq_needs_mie: assert property (p_irq_needs_mie)
    else $error("irq_ack raised while m_ie was low in the previous cycle");

endmodule

bind core_ctrl core_ctrl_sva u_core_ctrl_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .m_ie_i        (m_ie_i),
  .is_decoding_i (is_decoding_o),
  .irq_ack_i     (irq_ack_o),
  .pc_ctrl_i     (pc_ctrl_o)
);

`default_nettype wire

// ==== test/core_ctrl_tb.sv ====
`default_nettype none

module core_ctrl_tb;

  import ctrl_pkg::*;

  localparam int unsigned IRQ_ID_W = 5;
  // mcause values for illegal and for ecall from machine mode (8 plus priv 3)
  localparam logic [5:0] ILLEGAL_CAUSE = 6'd2;
  localparam logic [5:0] ECALL_M_CAUSE = 6'd8 | 6'd3;
  // cycles a wait loop may spin before the run is aborted
  localparam int WAIT_LIMIT = 10;

  logic                clk;
  logic                rst_n;
  logic                fetch_enable;
  logic                instr_valid;
  logic                id_ready;
  logic                branch_set;
  logic                jump_set;
  logic                branch_in_id;
  logic                multicycle;
  logic                irq_req;
  logic [IRQ_ID_W-1:0] irq_id;
  logic                m_ie;
  priv_lvl_e           priv;
  dec_evt_t            dec_evt;

  logic                busy;
  logic                instr_req;
  logic                halt_if;
  logic                halt_id;
  logic                first_fetch;
  logic                is_decoding;
  logic                deassert_we;
  pc_ctrl_t            pc_ctrl;
  csr_ctrl_t           csr_ctrl;
  logic [5:0]          exc_cause;
  logic [5:0]          csr_cause;
  logic                irq_ack;
  logic                exc_ack;
  logic [IRQ_ID_W-1:0] irq_id_out;

  integer              seed;
  logic [31:0]         rnd;

  core_ctrl #(
    .IRQ_ID_W (IRQ_ID_W)
  ) core_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .instr_valid_i  (instr_valid),
    .id_ready_i     (id_ready),
    .branch_set_i   (branch_set),
    .jump_set_i     (jump_set),
    .branch_in_id_i (branch_in_id),
    .multicycle_i   (multicycle),
    .irq_req_i      (irq_req),
    .irq_id_i       (irq_id),
    .m_ie_i         (m_ie),
    .priv_i         (priv),
    .dec_evt_i      (dec_evt),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .halt_if_o      (halt_if),
    .halt_id_o      (halt_id),
    .first_fetch_o  (first_fetch),
    .is_decoding_o  (is_decoding),
    .deassert_we_o  (deassert_we),
    .pc_ctrl_o      (pc_ctrl),
    .csr_ctrl_o     (csr_ctrl),
    .exc_cause_o    (exc_cause),
    .csr_cause_o    (csr_cause),
    .irq_ack_o      (irq_ack),
    .exc_ack_o      (exc_ack),
    .irq_id_o       (irq_id_out)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val == exp_val)
      else abort_run($sformatf("error %s expected %0h actual %0h", name, exp_val, act_val));
  endtask

  // inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // outputs are compared mid-cycle, long after they settled
  task automatic settle();
    @(negedge clk);
  endtask

  task automatic wait_decoding();
    int n;
    n = 0;
    settle();
    while (!is_decoding) begin
      if (n == WAIT_LIMIT) begin
        abort_run("timeout, the core never reached decode with a valid instruction");
      end else begin
        next_cycle();
        settle();
        n++;
      end
    end
  endtask

  task automatic wait_busy();
    int n;
    n = 0;
    settle();
    while (!busy) begin
      if (n == WAIT_LIMIT) begin
        abort_run("timeout, the core did not wake up from sleep");
      end else begin
        next_cycle();
        settle();
        n++;
      end
    end
  endtask

  // nothing may leave the controller while it sits in reset
  task automatic check_quiet(input string name);
    check_value({name, "_busy"}, 32'd0, 32'(busy));
    check_value({name, "_instr_req"}, 32'd0, 32'(instr_req));
    check_value({name, "_pc_set"}, 32'd0, 32'(pc_ctrl.pc_set));
    check_value({name, "_csr"}, 32'd0, 32'(csr_ctrl));
    check_value({name, "_irq_ack"}, 32'd0, 32'(irq_ack));
    check_value({name, "_exc_ack"}, 32'd0, 32'(exc_ack));
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    seed         = 32'he5ac4c2a;
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    instr_valid  = 1'b0;
    id_ready     = 1'b0;
    branch_set   = 1'b0;
    jump_set     = 1'b0;
    branch_in_id = 1'b0;
    multicycle   = 1'b0;
    irq_req      = 1'b0;
    irq_id       = '0;
    m_ie         = 1'b0;
    priv         = PRIV_LVL_M;
    dec_evt      = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // boot: idle until fetch enable, then one boot redirect
    settle();
    check_quiet("reset_idle");
    next_cycle();
    settle();
    check_quiet("reset_idle");
    next_cycle();
    fetch_enable = 1'b1;
    id_ready     = 1'b1;
    settle();
    check_value("boot_wait_busy", 32'd0, 32'(busy));
    next_cycle();
    settle();
    check_value("boot_pc_set", 32'd1, 32'(pc_ctrl.pc_set));
    check_value("boot_pc_sel", 32'(PC_BOOT), 32'(pc_ctrl.pc_sel));
    next_cycle();
    settle();
    check_value("boot_pc_set_once", 32'd0, 32'(pc_ctrl.pc_set));
    check_value("boot_first_fetch", 32'd1, 32'(first_fetch));
    next_cycle();
    instr_valid = 1'b1;
    wait_decoding();

    // jumps and branches redirect in the decode cycle itself
    repeat (4) begin
      next_cycle();
      rnd        = $random(seed);
      jump_set   = rnd[0];
      branch_set = ~rnd[0];
      settle();
      check_value("jump_pc_set", 32'd1, 32'(pc_ctrl.pc_set));
      check_value("jump_pc_sel", 32'(PC_JUMP), 32'(pc_ctrl.pc_sel));
      check_value("jump_we", 32'd0, 32'(deassert_we));
    end

    // illegal instruction, then the exception in the flush cycle
    next_cycle();
    jump_set        = 1'b0;
    branch_set      = 1'b0;
    dec_evt.illegal = 1'b1;
    settle();
    check_value("illegal_we", 32'd1, 32'(deassert_we));
    next_cycle();
    settle();
    check_value("illegal_pc_sel", 32'(PC_EXCEPTION), 32'(pc_ctrl.pc_sel));
    check_value("illegal_exc_pc", 32'(EXC_PC_ILLINSN), 32'(pc_ctrl.exc_pc_sel));
    check_value("illegal_cause", 32'(ILLEGAL_CAUSE), 32'(csr_cause));
    check_value("illegal_save_id", 32'd1, 32'(csr_ctrl.save_id));
    check_value("illegal_save_cause", 32'd1, 32'(csr_ctrl.save_cause));
    check_value("illegal_halt_id", 32'd1, 32'(halt_id));
    next_cycle();
    dec_evt = '0;
    wait_decoding();

    // ecall from machine mode
    next_cycle();
    dec_evt.ecall = 1'b1;
    next_cycle();
    settle();
    check_value("ecall_pc_sel", 32'(PC_EXCEPTION), 32'(pc_ctrl.pc_sel));
    check_value("ecall_exc_pc", 32'(EXC_PC_ECALL), 32'(pc_ctrl.exc_pc_sel));
    check_value("ecall_csr_cause", 32'(ECALL_M_CAUSE), 32'(csr_cause));
    check_value("ecall_exc_cause", 32'(ECALL_M_CAUSE), 32'(exc_cause));
    next_cycle();
    dec_evt = '0;
    wait_decoding();

    ////////////////////////////////////////
    // interrupts
    ////////////////////////////////////////

    repeat (3) begin
      next_cycle();
      m_ie        = 1'b1;
      instr_valid = 1'b0;
      rnd         = $random(seed);
      irq_id      = rnd[IRQ_ID_W-1:0];
      irq_req     = 1'b1;
      settle();
      check_value("irq_ack_early", 32'd0, 32'(irq_ack));
      next_cycle();
      settle();
      check_value("irq_ack", 32'd1, 32'(irq_ack));
      check_value("irq_exc_ack", 32'd1, 32'(exc_ack));
      check_value("irq_id_out", 32'(irq_id), 32'(irq_id_out));
      check_value("irq_csr_cause", 32'({1'b1, irq_id}), 32'(csr_cause));
      check_value("irq_exc_cause", 32'({1'b0, irq_id}), 32'(exc_cause));
      check_value("irq_save_if", 32'd1, 32'(csr_ctrl.save_if));
      next_cycle();
      irq_req     = 1'b0;
      instr_valid = 1'b1;
      wait_decoding();
    end

    // masked request is never taken
    next_cycle();
    instr_valid = 1'b0;
    m_ie        = 1'b0;
    irq_req     = 1'b1;
    repeat (20) begin
      settle();
      check_value("irq_masked", 32'd0, 32'(irq_ack));
      next_cycle();
    end
    irq_req     = 1'b0;
    m_ie        = 1'b1;
    instr_valid = 1'b1;
    wait_decoding();

    // mret with fetch enable low ends in sleep, irq wakes the core
    next_cycle();
    fetch_enable = 1'b0;
    dec_evt.mret = 1'b1;
    next_cycle();
    settle();
    check_value("mret_pc_set", 32'd1, 32'(pc_ctrl.pc_set));
    check_value("mret_pc_sel", 32'(PC_ERET), 32'(pc_ctrl.pc_sel));
    check_value("mret_restore", 32'd1, 32'(csr_ctrl.restore_mret));
    check_value("mret_we", 32'd1, 32'(deassert_we));
    next_cycle();
    dec_evt     = '0;
    instr_valid = 1'b0;
    settle();
    check_value("sleep_busy", 32'd0, 32'(busy));
    next_cycle();
    settle();
    check_value("sleep_busy_held", 32'd0, 32'(busy));
    check_value("sleep_instr_req", 32'd0, 32'(instr_req));
    check_value("sleep_halt_if", 32'd1, 32'(halt_if));
    next_cycle();
    irq_req = 1'b1;
    wait_busy();
    next_cycle();
    irq_req     = 1'b0;
    instr_valid = 1'b1;
    wait_decoding();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
